//--- src/nts_pkg.sv
package nts_pkg;

  // ------------------------------
  // NTP header constants
  // ------------------------------

  // Header length in 64-bit words
  localparam int NTP_WORDS = 6;

  // Server identity fields
  localparam logic [7:0] NTP_STRATUM = 8'd1;
  localparam logic [7:0] NTP_PRECISION = 8'hEC;

  // "GPS" followed by a zero byte
  localparam logic [31:0] NTP_REF_ID = 32'h4750_5300;

  // ------------------------------
  // Enumerations
  // ------------------------------

  // Association mode, bits 58:56 of header word 0
  typedef enum logic [2:0] {
    MODE_CLIENT = 3'd3,
    MODE_SERVER = 3'd4
  } ntp_mode_e;

  // Request parser states
  typedef enum logic [1:0] {
    RX_HEAD = 2'd0,
    RX_BODY = 2'd1,
    RX_SKIP = 2'd2,
    RX_HOLD = 2'd3
  } rx_state_e;

  // ------------------------------
  // Stream and request records
  // ------------------------------

  // One big-endian stream word with end-of-packet marker
  typedef struct packed {
    logic [63:0] data;
    logic        last;
  } ntp_beat_t;

  // Fields of a checked client request
  typedef struct packed {
    logic [2:0]  version;
    logic [7:0]  poll;
    // Client transmit timestamp, echoed back as origin
    logic [63:0] origin;
    // Local time when word 0 arrived
    logic [63:0] receive;
  } ntp_request_t;

endpackage

//--- src/nts_rx_parser.sv
module nts_rx_parser (
  input  logic                  i_clk,
  input  logic                  i_arst_n,

  input  logic [63:0]           i_ntp_time,

  input  logic                  i_rx_valid,
  input  nts_pkg::ntp_beat_t    i_rx_beat,
  output logic                  o_rx_ready,

  output logic                  o_rx_drop,

  output logic                  o_req_valid,
  output nts_pkg::ntp_request_t o_req,
  input  logic                  i_req_ready
);

  localparam logic [2:0] LAST_WORD = 3'(nts_pkg::NTP_WORDS - 1);

  nts_pkg::rx_state_e    state_q;
  nts_pkg::rx_state_e    state_d;
  logic [2:0]            word_q;
  logic [2:0]            word_d;
  logic                  drop_q;
  logic                  drop_d;
  nts_pkg::ntp_request_t req_q;

  logic                  rx_fire;
  logic                  head_ok;
  logic [2:0]            rx_version;
  logic [2:0]            rx_mode;

  // ------------------------------
  // Header field decode
  // ------------------------------

  // LI in 63:62, VN in 61:59, mode in 58:56
  assign rx_version = i_rx_beat.data[61:59];
  assign rx_mode    = i_rx_beat.data[58:56];

  assign head_ok = (rx_mode == nts_pkg::MODE_CLIENT) &&
                   ((rx_version == 3'd3) || (rx_version == 3'd4));

  assign o_rx_ready = (state_q != nts_pkg::RX_HOLD);
  assign rx_fire    = i_rx_valid && o_rx_ready;

  // ------------------------------
  // Packet FSM
  // ------------------------------

  always_comb
  begin
    state_d = state_q;
    word_d  = word_q;
    drop_d  = 1'b0;
    case (state_q)
      nts_pkg::RX_HEAD:
      begin
        if (rx_fire)
        begin
          // A one-word packet is short whatever its header says
          if (i_rx_beat.last)
            drop_d = 1'b1;
          else if (!head_ok)
            state_d = nts_pkg::RX_SKIP;
          else
          begin
            state_d = nts_pkg::RX_BODY;
            word_d  = 3'd1;
          end
        end
      end
      nts_pkg::RX_BODY:
      begin
        if (rx_fire)
        begin
          if (word_q == LAST_WORD)
            state_d = i_rx_beat.last ? nts_pkg::RX_HOLD : nts_pkg::RX_SKIP;
          else if (i_rx_beat.last)
          begin
            drop_d  = 1'b1;
            state_d = nts_pkg::RX_HEAD;
          end
          else
            word_d = word_q + 3'd1;
        end
      end
      nts_pkg::RX_SKIP:
      begin
        // Swallow the rest of a bad packet
        if (rx_fire && i_rx_beat.last)
        begin
          drop_d  = 1'b1;
          state_d = nts_pkg::RX_HEAD;
        end
      end
      nts_pkg::RX_HOLD:
      begin
        if (i_req_ready)
          state_d = nts_pkg::RX_HEAD;
      end
      default: state_d = nts_pkg::RX_HEAD;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      state_q <= nts_pkg::RX_HEAD;
      word_q  <= 3'd0;
      drop_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      word_q  <= word_d;
      drop_q  <= drop_d;
    end
  end

  // Request fields, receive time taken on the word 0 edge
  always_ff @(posedge i_clk)
  begin
    if (rx_fire && (state_q == nts_pkg::RX_HEAD))
    begin
      req_q.version <= rx_version;
      req_q.poll    <= i_rx_beat.data[47:40];
      req_q.receive <= i_ntp_time;
    end
    if (rx_fire && (state_q == nts_pkg::RX_BODY) && (word_q == LAST_WORD))
      req_q.origin <= i_rx_beat.data;
  end

  assign o_rx_drop   = drop_q;
  assign o_req_valid = (state_q == nts_pkg::RX_HOLD);
  assign o_req       = req_q;

  // Request held steady while the execute stage stalls
  a_req_stable : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_req_valid && !i_req_ready) |=> $stable(o_req));

endmodule

//--- src/nts_response_builder.sv
module nts_response_builder (
  input  logic                  i_clk,
  input  logic                  i_arst_n,

  input  logic [63:0]           i_ntp_time,

  input  logic                  i_req_valid,
  input  nts_pkg::ntp_request_t i_req,
  output logic                  o_req_ready,

  output logic                  o_wr_valid,
  output nts_pkg::ntp_beat_t    o_wr_beat,
  input  logic                  i_wr_ready
);

  localparam logic [2:0] LAST_IDX = 3'(nts_pkg::NTP_WORDS - 1);

  logic                  busy_q;
  logic [2:0]            idx_q;
  nts_pkg::ntp_request_t req_q;

  logic                  req_fire;
  logic                  wr_fire;
  logic [63:0]           word_data;

  assign o_req_ready = !busy_q;
  assign req_fire    = i_req_valid && o_req_ready;
  assign o_wr_valid  = busy_q;
  assign wr_fire     = o_wr_valid && i_wr_ready;

  // ------------------------------
  // Word sequencer
  // ------------------------------

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      busy_q <= 1'b0;
      idx_q  <= 3'd0;
    end
    else if (req_fire)
    begin
      busy_q <= 1'b1;
      idx_q  <= 3'd0;
    end
    else if (wr_fire)
    begin
      // Idle again once the transmit word has gone
      if (idx_q == LAST_IDX)
        busy_q <= 1'b0;
      else
        idx_q <= idx_q + 3'd1;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (req_fire)
      req_q <= i_req;
  end

  // ------------------------------
  // Server header words
  // ------------------------------

  always_comb
  begin
    case (idx_q)
      3'd0:
        // LI 0, client version, server mode, then stratum, poll, precision
        word_data = {2'b00, req_q.version, nts_pkg::MODE_SERVER,
                     nts_pkg::NTP_STRATUM, req_q.poll, nts_pkg::NTP_PRECISION,
                     32'h0000_0000};
      3'd1:
        word_data = {32'h0000_0000, nts_pkg::NTP_REF_ID};
      3'd2:
        word_data = req_q.receive;
      3'd3:
        word_data = req_q.origin;
      3'd4:
        word_data = req_q.receive;
      default:
        word_data = i_ntp_time;  // live transmit time
    endcase
  end

  assign o_wr_beat.data = word_data;
  assign o_wr_beat.last = (idx_q == LAST_IDX);

  // Sequencer stays inside the six header words
  a_idx_range : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    idx_q <= LAST_IDX);

endmodule

//--- src/nts_tx_buffer.sv
module nts_tx_buffer #(
  parameter int TX_DEPTH = 16
) (
  input  logic               i_clk,
  input  logic               i_arst_n,

  input  logic               i_wr_valid,
  input  nts_pkg::ntp_beat_t i_wr_beat,
  output logic               o_wr_ready,

  output logic               o_tx_valid,
  output nts_pkg::ntp_beat_t o_tx_beat,
  input  logic               i_tx_ready
);

  localparam int AW = $clog2(TX_DEPTH);
  localparam logic [AW:0] FULL_COUNT = (AW + 1)'(TX_DEPTH);

  nts_pkg::ntp_beat_t mem [TX_DEPTH];

  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;

  logic          full;
  logic          empty;
  logic          wr_en;
  logic          rd_en;

  assign full  = (count_q == FULL_COUNT);
  assign empty = (count_q == '0);
  assign wr_en = i_wr_valid && !full;
  assign rd_en = i_tx_ready && !empty;

  // ------------------------------
  // Storage and pointers
  // ------------------------------

  always_ff @(posedge i_clk)
  begin
    if (wr_en)
      mem[wr_ptr_q] <= i_wr_beat;
  end

  // Pointers wrap on their own, the depth being a power of two
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (wr_en && !rd_en)
        count_q <= count_q + 1'b1;
      else if (rd_en && !wr_en)
        count_q <= count_q - 1'b1;
    end
  end

  assign o_wr_ready = !full;
  assign o_tx_valid = !empty;
  assign o_tx_beat  = mem[rd_ptr_q];

  // No write slips in while full, no read while empty
  a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    full |=> (wr_ptr_q == $past(wr_ptr_q)));
  a_no_underflow : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    empty |=> (rd_ptr_q == $past(rd_ptr_q)));

endmodule

//--- src/nts_engine.sv
module nts_engine #(
  parameter int TX_DEPTH = 16
) (
  input  logic               i_clk,
  input  logic               i_arst_n,

  input  logic [63:0]        i_ntp_time,

  input  logic               i_rx_valid,
  input  nts_pkg::ntp_beat_t i_rx_beat,
  output logic               o_rx_ready,
  output logic               o_rx_drop,

  output logic               o_tx_valid,
  output nts_pkg::ntp_beat_t o_tx_beat,
  input  logic               i_tx_ready
);

  // ------------------------------
  // Stage links
  // ------------------------------

  logic                  req_valid;
  logic                  req_ready;
  nts_pkg::ntp_request_t req;

  logic                  wr_valid;
  logic                  wr_ready;
  nts_pkg::ntp_beat_t    wr_beat;

  // Decode
  nts_rx_parser parser (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_ntp_time  (i_ntp_time),
    .i_rx_valid  (i_rx_valid),
    .i_rx_beat   (i_rx_beat),
    .o_rx_ready  (o_rx_ready),
    .o_rx_drop   (o_rx_drop),
    .o_req_valid (req_valid),
    .o_req       (req),
    .i_req_ready (req_ready)
  );

  // Execute
  nts_response_builder builder (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_ntp_time  (i_ntp_time),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_req_ready (req_ready),
    .o_wr_valid  (wr_valid),
    .o_wr_beat   (wr_beat),
    .i_wr_ready  (wr_ready)
  );

  // Result
  nts_tx_buffer #(
    .TX_DEPTH (TX_DEPTH)
  ) tx_buffer (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_wr_valid (wr_valid),
    .i_wr_beat  (wr_beat),
    .o_wr_ready (wr_ready),
    .o_tx_valid (o_tx_valid),
    .o_tx_beat  (o_tx_beat),
    .i_tx_ready (i_tx_ready)
  );

endmodule

//--- dv/tb_nts_engine.sv
module tb_nts_engine;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 500;

  // Server header fields expected in every response
  localparam logic [7:0]  STRATUM   = 8'd1;
  localparam logic [7:0]  PRECISION = 8'hEC;
  localparam logic [31:0] REF_ID    = {"GPS", 8'h00};

  logic               i_clk = 1'b0;
  logic               i_arst_n;
  logic [63:0]        i_ntp_time = 64'h0000_1000_0000_0000;
  logic               i_rx_valid;
  nts_pkg::ntp_beat_t i_rx_beat;
  logic               o_rx_ready;
  logic               o_rx_drop;
  logic               o_tx_valid;
  nts_pkg::ntp_beat_t o_tx_beat;
  logic               i_tx_ready;

  logic [31:0] lcg_state = 32'hd682d607;
  int          drop_count = 0;

  // Per-request expectations indexed by slot
  logic [2:0]  exp_ver    [8];
  logic [7:0]  exp_poll   [8];
  logic [63:0] exp_origin [8];
  logic [63:0] exp_recv   [8];

  nts_engine #(
    .TX_DEPTH (16)
  ) UUT (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_ntp_time (i_ntp_time),
    .i_rx_valid (i_rx_valid),
    .i_rx_beat  (i_rx_beat),
    .o_rx_ready (o_rx_ready),
    .o_rx_drop  (o_rx_drop),
    .o_tx_valid (o_tx_valid),
    .o_tx_beat  (o_tx_beat),
    .i_tx_ready (i_tx_ready)
  );

  always
  begin
    #20;
    i_clk = ~i_clk;
  end

  // NTP time advances once per cycle just after the edge
  always
  begin
    @(posedge i_clk);
    #2;
    i_ntp_time = i_ntp_time + 64'd1;
  end

  // Drop pulses counted mid-cycle where the output is settled
  always @(negedge i_clk)
  begin
    if (o_rx_drop)
      drop_count <= drop_count + 1;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [2:0] pick_version();
    logic [31:0] r;
    r = lcg_next();
    return r[20] ? 3'd3 : 3'd4;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual)
      stop_on_error($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge i_clk);
      #2;
    end
  endtask

  // Response word as the server header rule defines it
  function automatic logic [63:0] expected_word(input int slot, input int n);
    case (n)
      0: return {2'b00, exp_ver[slot], 3'd4, STRATUM, exp_poll[slot], PRECISION, 32'd0};
      1: return {32'd0, REF_ID};
      3: return exp_origin[slot];
      default: return exp_recv[slot];
    endcase
  endfunction

  task automatic send_packet(input int slot, input logic [2:0] ver, input logic [2:0] mode,
                             input int nwords, input bit stalls);
    logic [63:0] data;
    int          gap;
    int          wait_cycles;
    exp_ver[slot]  = ver;
    exp_poll[slot] = 8'(lcg_next());
    for (int i = 0; i < nwords; i++)
    begin
      if (i == 0)
        data = {2'b00, ver, mode, 8'd0, exp_poll[slot], 8'd0, 32'd0};
      else
        data = {lcg_next(), lcg_next()};
      if (i == 5)
        exp_origin[slot] = data;
      if (stalls)
      begin
        gap = lcg_next() % 4;
        i_rx_valid = 1'b0;
        idle_cycles(gap);
      end
      i_rx_valid     = 1'b1;
      i_rx_beat.data = data;
      i_rx_beat.last = (i == nwords - 1);
      wait_cycles    = 0;
      @(negedge i_clk);
      while (!o_rx_ready)
      begin
        wait_cycles++;
        if (wait_cycles > WAIT_LIMIT)
          stop_on_error("Input stream never became ready");
        @(negedge i_clk);
      end
      // Time seen by the DUT on the word 0 transfer edge
      if (i == 0)
        exp_recv[slot] = i_ntp_time;
      @(posedge i_clk);
      #2;
    end
    i_rx_valid = 1'b0;
    i_rx_beat  = '0;
  endtask

  task automatic drive_ready(input bit random_ready);
    logic [31:0] r;
    if (random_ready)
    begin
      r = lcg_next();
      i_tx_ready = r[16];
    end
    else
      i_tx_ready = 1'b1;
  endtask

  task automatic receive_response(input int slot, input bit random_ready, input string name);
    logic [63:0] words [6];
    logic [63:0] seen_time;
    int          wait_cycles;
    for (int n = 0; n < 6; n++)
    begin
      wait_cycles = 0;
      drive_ready(random_ready);
      @(negedge i_clk);
      while (!(o_tx_valid && i_tx_ready))
      begin
        wait_cycles++;
        if (wait_cycles > WAIT_LIMIT)
          stop_on_error($sformatf("%s: response word %0d never arrived", name, n));
        @(posedge i_clk);
        #2;
        drive_ready(random_ready);
        @(negedge i_clk);
      end
      words[n] = o_tx_beat.data;
      check($sformatf("%s word %0d last", name, n), 64'(n == 5), 64'(o_tx_beat.last));
      seen_time = i_ntp_time;
      @(posedge i_clk);
      #2;
    end
    i_tx_ready = 1'b0;
    for (int n = 0; n < 5; n++)
      check($sformatf("%s word %0d", name, n), expected_word(slot, n), words[n]);
    // Transmit time is live, so only a window is known
    if ((words[5] < exp_recv[slot]) || (words[5] > seen_time))
      stop_on_error($sformatf("FAIL %s word 5 expected %h to %h actual %h", name,
                              exp_recv[slot], seen_time, words[5]));
  endtask

  task automatic wait_for_drop(input int target);
    int wait_cycles;
    wait_cycles = 0;
    @(negedge i_clk);
    while (drop_count < target)
    begin
      wait_cycles++;
      if (wait_cycles > WAIT_LIMIT)
        stop_on_error("A bad packet gave no drop pulse");
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #2;
  endtask

  task automatic reject_packet(input string name, input logic [2:0] ver,
                               input logic [2:0] mode, input int nwords);
    int target;
    target = drop_count + 1;
    send_packet(7, ver, mode, nwords, 1'b0);
    wait_for_drop(target);
    idle_cycles(4);
    check({name, " drop count"}, 64'(target), 64'(drop_count));
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic test_single();
    send_packet(0, 3'd4, 3'd3, 6, 1'b0);
    receive_response(0, 1'b0, "single v4");
    send_packet(1, 3'd3, 3'd3, 6, 1'b0);
    receive_response(1, 1'b0, "single v3");
  endtask

  task automatic test_bad_packets();
    reject_packet("mode 1", 3'd4, 3'd1, 6);
    reject_packet("version 2", 3'd2, 3'd3, 6);
    reject_packet("four words", 3'd4, 3'd3, 4);
    reject_packet("eight words", 3'd4, 3'd3, 8);
    @(negedge i_clk);
    check("bad packets output", 64'd0, 64'(o_tx_valid));
    @(posedge i_clk);
    #2;
    // Parser must recover for a good packet
    send_packet(2, 3'd4, 3'd3, 6, 1'b0);
    receive_response(2, 1'b0, "after bad packets");
  endtask

  task automatic test_back_to_back();
    fork
      begin
        for (int k = 0; k < 3; k++)
          send_packet(k, pick_version(), 3'd3, 6, 1'b0);
      end
      begin
        for (int k = 0; k < 3; k++)
          receive_response(k, 1'b0, $sformatf("back to back %0d", k));
      end
    join
  endtask

  task automatic test_backpressure();
    // Output held off, so the FIFO fills and the input stalls
    for (int k = 0; k < 4; k++)
      send_packet(k, pick_version(), 3'd3, 6, 1'b0);
    @(negedge i_clk);
    check("backpressure fifo holds words", 64'd1, 64'(o_tx_valid));
    check("backpressure input stalled", 64'd0, 64'(o_rx_ready));
    @(posedge i_clk);
    #2;
    for (int k = 0; k < 4; k++)
      receive_response(k, 1'b1, $sformatf("backpressure %0d", k));
  endtask

  task automatic test_input_stalls();
    for (int k = 0; k < 3; k++)
    begin
      send_packet(k, pick_version(), 3'd3, 6, 1'b1);
      receive_response(k, 1'b0, $sformatf("input stalls %0d", k));
    end
  endtask

  initial
  begin
    i_arst_n   = 1'b0;
    i_rx_valid = 1'b0;
    i_rx_beat  = '0;
    i_tx_ready = 1'b0;
    repeat (8) @(posedge i_clk);
    #2;
    i_arst_n = 1'b1;
    @(negedge i_clk);
    check("reset rx ready", 64'd1, 64'(o_rx_ready));
    check("reset tx valid", 64'd0, 64'(o_tx_valid));
    check("reset drop", 64'd0, 64'(o_rx_drop));
    @(posedge i_clk);
    #2;
    test_single();
    test_bad_packets();
    test_back_to_back();
    test_backpressure();
    test_input_stalls();
    $display("test passed");
    $finish;
  end

endmodule

//--- sim.f
src/nts_pkg.sv
src/nts_rx_parser.sv
src/nts_response_builder.sv
src/nts_tx_buffer.sv
src/nts_engine.sv
dv/tb_nts_engine.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_nts_engine -f sim.f \
  -o tb_nts_engine \
  && ./obj_dir/tb_nts_engine \
  || exit 1
